/* hw/rename_cfg_pkg.sv */
package rename_cfg_pkg;

    // ======================================================================
    // register file and checkpoint sizes
    // ======================================================================

    parameter int NUM_ARCH = 32;  // architectural registers.
    parameter int NUM_PHYS = 64;  // physical registers.
    parameter int NUM_CKPT = 4;   // checkpoint pages per bank.

    // free registers beyond the architectural set.
    parameter int FL_DEPTH = NUM_PHYS - NUM_ARCH;

    // ======================================================================
    // index types
    // ======================================================================

    typedef logic [$clog2(NUM_ARCH)-1:0] arch_reg_t;
    typedef logic [$clog2(NUM_PHYS)-1:0] phys_reg_t;
    typedef logic [$clog2(NUM_CKPT)-1:0] ckpt_id_t;

    // free list pointer with one wrap bit above the index.
    // full and empty differ only in the wrap bit.
    typedef logic [$clog2(FL_DEPTH):0] fl_ptr_t;

endpackage

/* hw/rename_if_pkg.sv */
package rename_if_pkg;

    // ======================================================================
    // rename request and result
    // ======================================================================

    // one instruction to rename.
    typedef struct packed {
        rename_cfg_pkg::arch_reg_t rs1;
        rename_cfg_pkg::arch_reg_t rs2;
        rename_cfg_pkg::arch_reg_t rd;
        logic                      has_rd;     // needs a new destination.
        logic                      save_ckpt;  // keep state after this branch.
        rename_cfg_pkg::ckpt_id_t  ckpt_id;
    } rename_req_t;

    typedef struct packed {
        rename_cfg_pkg::phys_reg_t ps1;
        rename_cfg_pkg::phys_reg_t ps2;
        rename_cfg_pkg::phys_reg_t pd_new;  // zero without a destination.
        rename_cfg_pkg::phys_reg_t pd_old;  // freed later at retire.
    } rename_rsp_t;

    // ======================================================================
    // retire and branch pulses
    // ======================================================================

    typedef struct packed {
        logic                      valid;
        rename_cfg_pkg::phys_reg_t preg;
    } commit_t;

    typedef struct packed {
        logic                     valid;
        rename_cfg_pkg::ckpt_id_t ckpt_id;
    } restore_t;

endpackage

/* hw/ckpt_bank.sv */
module ckpt_bank #(
    parameter type payload_t = logic [7:0],
    parameter int  NUM_CKPT  = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     save,
    input  rename_cfg_pkg::ckpt_id_t save_id,
    input  payload_t                 save_data,
    input  rename_cfg_pkg::ckpt_id_t rd_id,
    output payload_t                 rd_data
);

    // one page per outstanding branch.
    payload_t pages_q [NUM_CKPT];

    // pages clear at reset and load on save.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_CKPT; i++) begin
                pages_q[i] <= '0;
            end
        end else if (save) begin
            pages_q[save_id] <= save_data;
        end
    end

    assign rd_data = pages_q[rd_id];  // combinational read.

endmodule

/* hw/free_list.sv */
module free_list #(
    parameter int NUM_ARCH = 32,
    parameter int NUM_PHYS = 64,
    parameter int NUM_CKPT = 4
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      pop,
    output rename_cfg_pkg::phys_reg_t head_preg,
    output logic                      empty,
    input  rename_if_pkg::commit_t    push,
    input  logic                      save,
    input  rename_cfg_pkg::ckpt_id_t  save_id,
    input  rename_if_pkg::restore_t   restore
);

    localparam int DEPTH = NUM_PHYS - NUM_ARCH;
    localparam int IDX_W = $clog2(DEPTH);

    rename_cfg_pkg::phys_reg_t queue_q [DEPTH];

    rename_cfg_pkg::fl_ptr_t rd_ptr_q;
    rename_cfg_pkg::fl_ptr_t wr_ptr_q;
    rename_cfg_pkg::fl_ptr_t rd_ptr_next;
    rename_cfg_pkg::fl_ptr_t count;
    rename_cfg_pkg::fl_ptr_t ckpt_ptr;
    logic                    do_pop;

    // ======================================================================
    // head and occupancy
    // ======================================================================

    assign count     = wr_ptr_q - rd_ptr_q;  // wrap bit keeps full apart from empty.
    assign empty     = (count == '0);
    assign head_preg = queue_q[rd_ptr_q[IDX_W-1:0]];

    assign do_pop      = pop && !empty;
    assign rd_ptr_next = do_pop ? rd_ptr_q + 1'b1 : rd_ptr_q;

    // ======================================================================
    // pointers
    // ======================================================================

    // after reset every non-architectural register is free.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= rename_cfg_pkg::fl_ptr_t'(DEPTH);
        end else begin
            if (restore.valid) begin
                rd_ptr_q <= ckpt_ptr;  // allocations since the checkpoint come back.
            end else begin
                rd_ptr_q <= rd_ptr_next;
            end
            // commits land at the tail and survive a restore.
            if (push.valid) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
        end
    end

    // ======================================================================
    // storage
    // ======================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                queue_q[i] <= rename_cfg_pkg::phys_reg_t'(NUM_ARCH + i);
            end
        end else if (push.valid) begin
            queue_q[wr_ptr_q[IDX_W-1:0]] <= push.preg;
        end
    end

    // a checkpoint only needs the head, taken after this cycle's pop.
    ckpt_bank #(
        .payload_t (rename_cfg_pkg::fl_ptr_t),
        .NUM_CKPT  (NUM_CKPT)
    ) u_ckpt (
        .clk       (clk),
        .rst_n     (rst_n),
        .save      (save),
        .save_id   (save_id),
        .save_data (rd_ptr_next),
        .rd_id     (restore.ckpt_id),
        .rd_data   (ckpt_ptr)
    );

endmodule

/* hw/map_table.sv */
module map_table #(
    parameter int NUM_ARCH = 32
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  rename_cfg_pkg::arch_reg_t rs1,
    input  rename_cfg_pkg::arch_reg_t rs2,
    input  rename_cfg_pkg::arch_reg_t rd,
    output rename_cfg_pkg::phys_reg_t ps1,
    output rename_cfg_pkg::phys_reg_t ps2,
    output rename_cfg_pkg::phys_reg_t pd_old,
    input  logic                      upd_en,
    input  rename_cfg_pkg::phys_reg_t upd_preg,
    input  logic                      save,
    input  rename_cfg_pkg::ckpt_id_t  save_id,
    input  rename_if_pkg::restore_t   restore
);

    // whole table as one vector, so a checkpoint is a single page.
    typedef rename_cfg_pkg::phys_reg_t [NUM_ARCH-1:0] map_vec_t;

    map_vec_t map_q;
    map_vec_t map_next;
    map_vec_t ckpt_map;

    // ======================================================================
    // lookup
    // ======================================================================

    // sources read the table before this request's own update.
    assign ps1    = map_q[rs1];
    assign ps2    = map_q[rs2];
    assign pd_old = map_q[rd];

    // ======================================================================
    // update and restore
    // ======================================================================

    always_comb begin
        map_next = map_q;
        if (upd_en) begin
            map_next[rd] = upd_preg;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_ARCH; i++) begin
                map_q[i] <= rename_cfg_pkg::phys_reg_t'(i);  // identity map.
            end
        end else if (restore.valid) begin
            map_q <= ckpt_map;
        end else begin
            map_q <= map_next;
        end
    end

    // saved page already holds the branch's own destination.
    ckpt_bank #(
        .payload_t (map_vec_t),
        .NUM_CKPT  (rename_cfg_pkg::NUM_CKPT)
    ) u_ckpt (
        .clk       (clk),
        .rst_n     (rst_n),
        .save      (save),
        .save_id   (save_id),
        .save_data (map_next),
        .rd_id     (restore.ckpt_id),
        .rd_data   (ckpt_map)
    );

endmodule

/* hw/rename_ctrl.sv */
module rename_ctrl (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       req,
    input  rename_if_pkg::rename_req_t rename_req,
    output logic                       ack,
    output rename_if_pkg::rename_rsp_t rename_rsp,
    output rename_cfg_pkg::arch_reg_t  map_rs1,
    output rename_cfg_pkg::arch_reg_t  map_rs2,
    output rename_cfg_pkg::arch_reg_t  map_rd,
    input  rename_cfg_pkg::phys_reg_t  map_ps1,
    input  rename_cfg_pkg::phys_reg_t  map_ps2,
    input  rename_cfg_pkg::phys_reg_t  map_pd_old,
    output logic                       upd_en,
    output rename_cfg_pkg::phys_reg_t  upd_preg,
    output logic                       pop,
    input  rename_cfg_pkg::phys_reg_t  head_preg,
    input  logic                       empty,
    output logic                       save,
    output rename_cfg_pkg::ckpt_id_t   save_id
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ALLOC,
        ST_ACK
    } state_t;

    state_t                     state_q;
    state_t                     state_d;
    rename_if_pkg::rename_req_t req_q;
    rename_if_pkg::rename_rsp_t rsp_d;
    logic                       go;

    // stall only when a destination is needed and none is free.
    assign go = (state_q == ST_ALLOC) && (!req_q.has_rd || !empty);

    assign map_rs1  = req_q.rs1;
    assign map_rs2  = req_q.rs2;
    assign map_rd   = req_q.rd;
    assign pop      = go && req_q.has_rd;
    assign upd_en   = pop;        // map and free list move together.
    assign upd_preg = head_preg;
    assign save     = go && req_q.save_ckpt;
    assign save_id  = req_q.ckpt_id;
    assign ack      = (state_q == ST_ACK);

    always_comb begin
        rsp_d.ps1    = map_ps1;
        rsp_d.ps2    = map_ps2;
        rsp_d.pd_new = req_q.has_rd ? head_preg : '0;
        rsp_d.pd_old = map_pd_old;
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:  if (req) state_d = ST_ALLOC;
            ST_ALLOC: if (go) state_d = ST_ACK;
            ST_ACK:   if (!req) state_d = ST_IDLE;  // four-phase return.
            default:  state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && req) begin
            req_q <= rename_req;
        end
        if (go) begin
            rename_rsp <= rsp_d;  // held until the next rename.
        end
    end

endmodule

/* hw/rename_top.sv */
module rename_top #(
    parameter int NUM_ARCH = rename_cfg_pkg::NUM_ARCH,
    parameter int NUM_PHYS = rename_cfg_pkg::NUM_PHYS,
    parameter int NUM_CKPT = rename_cfg_pkg::NUM_CKPT
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       req,
    input  rename_if_pkg::rename_req_t rename_req,
    output logic                       ack,
    output rename_if_pkg::rename_rsp_t rename_rsp,
    input  rename_if_pkg::commit_t     commit,
    input  rename_if_pkg::restore_t    restore
);

    rename_cfg_pkg::arch_reg_t map_rs1;
    rename_cfg_pkg::arch_reg_t map_rs2;
    rename_cfg_pkg::arch_reg_t map_rd;
    rename_cfg_pkg::phys_reg_t map_ps1;
    rename_cfg_pkg::phys_reg_t map_ps2;
    rename_cfg_pkg::phys_reg_t map_pd_old;
    rename_cfg_pkg::phys_reg_t upd_preg;
    rename_cfg_pkg::phys_reg_t head_preg;
    rename_cfg_pkg::ckpt_id_t  save_id;
    logic                      upd_en;
    logic                      pop;
    logic                      empty;
    logic                      save;

    rename_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .rename_req (rename_req),
        .ack        (ack),
        .rename_rsp (rename_rsp),
        .map_rs1    (map_rs1),
        .map_rs2    (map_rs2),
        .map_rd     (map_rd),
        .map_ps1    (map_ps1),
        .map_ps2    (map_ps2),
        .map_pd_old (map_pd_old),
        .upd_en     (upd_en),
        .upd_preg   (upd_preg),
        .pop        (pop),
        .head_preg  (head_preg),
        .empty      (empty),
        .save       (save),
        .save_id    (save_id)
    );

    map_table #(
        .NUM_ARCH (NUM_ARCH)
    ) u_map_table (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (map_rs1),
        .rs2      (map_rs2),
        .rd       (map_rd),
        .ps1      (map_ps1),
        .ps2      (map_ps2),
        .pd_old   (map_pd_old),
        .upd_en   (upd_en),
        .upd_preg (upd_preg),
        .save     (save),
        .save_id  (save_id),
        .restore  (restore)
    );

    // retire frees the old register straight into the tail.
    free_list #(
        .NUM_ARCH (NUM_ARCH),
        .NUM_PHYS (NUM_PHYS),
        .NUM_CKPT (NUM_CKPT)
    ) u_free_list (
        .clk       (clk),
        .rst_n     (rst_n),
        .pop       (pop),
        .head_preg (head_preg),
        .empty     (empty),
        .push      (commit),
        .save      (save),
        .save_id   (save_id),
        .restore   (restore)
    );

endmodule

/* dv/rename_asserts.sv */
module rename_asserts #(
    parameter int FL_DEPTH = 32
) (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    req,
    input logic                    ack,
    input rename_if_pkg::restore_t restore,
    input rename_cfg_pkg::fl_ptr_t fl_count
);
    timeunit 1ns;
    timeprecision 1ps;

    int fails = 0;  // failed properties so far.

    // ack only answers a request that was up on the edge that raised it.
    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(req))
        else begin
            $error("ack rose while req was low");
            fails++;
        end

    ack_holds: assert property (@(posedge clk) disable iff (!rst_n) ack && req |=> ack)
        else begin
            $error("ack fell while req was still high");
            fails++;
        end

    ack_drops: assert property (@(posedge clk) disable iff (!rst_n) ack && !req |=> !ack)
        else begin
            $error("ack stayed high after req fell");
            fails++;
        end

    restore_idle: assert property (@(posedge clk) disable iff (!rst_n)
        restore.valid |-> !req && !ack)
        else begin
            $error("restore arrived during a rename handshake");
            fails++;
        end

    // never more free entries than registers outside the architectural set.
    fl_bound: assert property (@(posedge clk) disable iff (!rst_n) fl_count <= FL_DEPTH)
        else begin
            $error("free list holds %0d entries", fl_count);
            fails++;
        end

endmodule

bind rename_top rename_asserts #(
    .FL_DEPTH (NUM_PHYS - NUM_ARCH)
) u_asserts (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .ack      (ack),
    .restore  (restore),
    .fl_count (u_free_list.count)
);

/* dv/rename_tb.sv */
module rename_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ARCH = rename_cfg_pkg::NUM_ARCH;
    localparam int NUM_PHYS = rename_cfg_pkg::NUM_PHYS;
    localparam int NUM_CKPT = rename_cfg_pkg::NUM_CKPT;
    localparam int TIMEOUT  = 64;

    logic                       clk;
    logic                       rst_n;
    logic                       req;
    logic                       ack;
    rename_if_pkg::rename_req_t rename_req;
    rename_if_pkg::rename_rsp_t rename_rsp;
    rename_if_pkg::commit_t     commit;
    rename_if_pkg::restore_t    restore;

    // reference model.
    rename_cfg_pkg::phys_reg_t  ref_map [NUM_ARCH];
    rename_cfg_pkg::phys_reg_t  ckpt_map [NUM_CKPT][NUM_ARCH];
    int                         ckpt_mark [NUM_CKPT];  // allocations up to and including the save.
    rename_cfg_pkg::phys_reg_t  free_q [$];
    rename_cfg_pkg::phys_reg_t  alloc_log [$];
    rename_cfg_pkg::phys_reg_t  retire_q [$];  // old registers waiting for commit.
    rename_if_pkg::rename_rsp_t exp_q [$];
    rename_if_pkg::rename_rsp_t cur_exp;
    logic [31:0]                lfsr;
    logic                       ack_seen;
    int                         rsp_errs;
    int                         ack_errs;
    int                         other_errs;

    rename_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ======================================================================
    // stimulus helpers and reference model
    // ======================================================================

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic rename_if_pkg::rename_req_t make_req(int rs1, int rs2, int rd,
                                                            logic has_rd, logic save, int id);
        rename_if_pkg::rename_req_t r;
        r.rs1       = rename_cfg_pkg::arch_reg_t'(rs1);
        r.rs2       = rename_cfg_pkg::arch_reg_t'(rs2);
        r.rd        = rename_cfg_pkg::arch_reg_t'(rd);
        r.has_rd    = has_rd;
        r.save_ckpt = save;
        r.ckpt_id   = rename_cfg_pkg::ckpt_id_t'(id);
        return r;
    endfunction

    // sources see the map before this request, a checkpoint sees it after.
    function automatic rename_if_pkg::rename_rsp_t predict_rsp(rename_if_pkg::rename_req_t r);
        rename_if_pkg::rename_rsp_t p;
        p.ps1    = ref_map[r.rs1];
        p.ps2    = ref_map[r.rs2];
        p.pd_old = ref_map[r.rd];
        p.pd_new = '0;
        if (r.has_rd) begin
            p.pd_new = free_q.pop_front();
            alloc_log.push_back(p.pd_new);
            retire_q.push_back(p.pd_old);
            ref_map[r.rd] = p.pd_new;
        end
        if (r.save_ckpt) begin
            for (int i = 0; i < NUM_ARCH; i++) begin
                ckpt_map[r.ckpt_id][i] = ref_map[i];
            end
            ckpt_mark[r.ckpt_id] = alloc_log.size();
        end
        return p;
    endfunction

    task automatic check_rsp(rename_if_pkg::rename_rsp_t got, rename_if_pkg::rename_rsp_t exp);
        if (got !== exp) begin
            $display("ERROR rename_rsp got %h expected %h at %0t", got, exp, $time);
            rsp_errs++;
        end
    endtask

    task automatic check_ack(logic got, logic exp, string when);
        if (got !== exp) begin
            $display("ERROR ack got %h expected %h %s at %0t", got, exp, when, $time);
            ack_errs++;
        end
    endtask

    task automatic wait_ack(logic level, string when);
        int n;
        n = 0;
        while (ack !== level && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (ack !== level) begin
            $display("timed out waiting for ack to reach %0d %s", level, when);
            other_errs++;
        end
    endtask

    task automatic finish_req(int hold);
        repeat (hold) begin
            @(negedge clk);
            check_ack(ack, 1'b1, "while req is held");
        end
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        check_ack(ack, 1'b1, "before req low is seen");
        wait_ack(1'b0, "after req fell");
    endtask

    task automatic rename(rename_if_pkg::rename_req_t r, int hold);
        exp_q.push_back(predict_rsp(r));
        @(posedge clk);
        rename_req <= r;
        req        <= 1'b1;
        repeat (2) @(negedge clk);
        check_ack(ack, 1'b0, "one edge after req");
        @(negedge clk);
        check_ack(ack, 1'b1, "two edges after req");
        wait_ack(1'b1, "for a rename");
        finish_req(hold);
    endtask

    task automatic retire_oldest();
        rename_cfg_pkg::phys_reg_t p;
        p = retire_q.pop_front();
        free_q.push_back(p);
        @(posedge clk);
        commit <= '{valid: 1'b1, preg: p};
        @(posedge clk);
        commit <= '0;
    endtask

    // younger allocations return to the head, commits stay at the tail.
    task automatic restore_ckpt(int id);
        int young;
        young = alloc_log.size() - ckpt_mark[id];
        for (int i = 0; i < NUM_ARCH; i++) begin
            ref_map[i] = ckpt_map[id][i];
        end
        repeat (young) begin
            free_q.push_front(alloc_log.pop_back());
            void'(retire_q.pop_back());
        end
        @(posedge clk);
        restore <= '{valid: 1'b1, ckpt_id: rename_cfg_pkg::ckpt_id_t'(id)};
        @(posedge clk);
        restore <= '0;
    endtask

    // ======================================================================
    // compare process
    // ======================================================================

    always @(negedge clk) begin
        if (ack === 1'b1) begin
            if (!ack_seen) begin
                if (exp_q.size() == 0) begin
                    $display("ack rose with no rename outstanding at %0t", $time);
                    other_errs++;
                end else begin
                    cur_exp = exp_q.pop_front();
                end
            end
            check_rsp(rename_rsp, cur_exp);  // held while ack is high.
        end
        ack_seen = (ack === 1'b1);
    end

    // ======================================================================
    // test sequence
    // ======================================================================

    initial begin
        rename_if_pkg::rename_req_t r;
        lfsr       = 32'h9948;
        ack_seen   = 1'b0;
        rsp_errs   = 0;
        ack_errs   = 0;
        other_errs = 0;
        rst_n      = 1'b0;
        req        = 1'b0;
        rename_req = '0;
        commit     = '0;
        restore    = '0;
        for (int i = 0; i < NUM_ARCH; i++) begin
            ref_map[i] = rename_cfg_pkg::phys_reg_t'(i);
        end
        for (int i = NUM_ARCH; i < NUM_PHYS; i++) begin
            free_q.push_back(rename_cfg_pkg::phys_reg_t'(i));
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_ack(ack, 1'b0, "after reset");

        rename(make_req(3, 7, 5, 1'b1, 1'b0, 0), 0);  // identity sources and pd_new 32.
        rename(make_req(9, 5, 9, 1'b1, 1'b0, 0), 0);
        rename(make_req(9, 9, 2, 1'b1, 1'b0, 0), 0);
        repeat (9) rename(make_req(rand_bits(5), rand_bits(5), rand_bits(5), 1'b1, 1'b0, 0), 0);

        // commits land at the tail and are reused after the wrap.
        repeat (8) retire_oldest();
        repeat (24) rename(make_req(rand_bits(5), rand_bits(5), rand_bits(5), 1'b1, 1'b0, 0), 0);

        rename(make_req(1, 2, 4, 1'b1, 1'b1, 2), 0);
        repeat (2) retire_oldest();
        rename(make_req(4, 4, 6, 1'b1, 1'b0, 0), 0);
        rename(make_req(6, 4, 8, 1'b1, 1'b0, 0), 0);
        rename(make_req(8, 6, 4, 1'b1, 1'b0, 0), 1);
        restore_ckpt(2);
        rename(make_req(6, 4, 8, 1'b1, 1'b0, 0), 0);

        // drain the list, then stall until a commit arrives.
        while (free_q.size() > 0) begin
            rename(make_req(rand_bits(5), rand_bits(5), rand_bits(5), 1'b1, 1'b0, 0), 0);
        end
        rename(make_req(rand_bits(5), rand_bits(5), rand_bits(5), 1'b0, 1'b0, 0), 0);
        r = make_req(rand_bits(5), rand_bits(5), rand_bits(5), 1'b1, 1'b0, 0);
        @(posedge clk);
        rename_req <= r;
        req        <= 1'b1;
        repeat (16) begin
            @(negedge clk);
            check_ack(ack, 1'b0, "while the free list is empty");
        end
        retire_oldest();
        exp_q.push_back(predict_rsp(r));
        wait_ack(1'b1, "after a commit refilled the list");
        finish_req(0);

        retire_oldest();
        rename(make_req(rand_bits(5), rand_bits(5), rand_bits(5), 1'b1, 1'b0, 0), 3);

        repeat (4) @(negedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d renames were never acknowledged", exp_q.size());
            other_errs++;
        end
        $display("rsp errors %0d, ack errors %0d, other failures %0d, assertion failures %0d",
                 rsp_errs, ack_errs, other_errs, DUT.u_asserts.fails);
        if (rsp_errs + ack_errs + other_errs + DUT.u_asserts.fails == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* project.f */
hw/rename_cfg_pkg.sv
hw/rename_if_pkg.sv
hw/ckpt_bank.sv
hw/free_list.sv
hw/map_table.sv
hw/rename_ctrl.sv
hw/rename_top.sv
dv/rename_asserts.sv
dv/rename_tb.sv

/* Bender.yml */
package:
  name: rename_stage

sources:
  # packages first, the RTL depends on them
  - hw/rename_cfg_pkg.sv
  - hw/rename_if_pkg.sv
  - hw/ckpt_bank.sv
  - hw/free_list.sv
  - hw/map_table.sv
  - hw/rename_ctrl.sv
  - hw/rename_top.sv
  - target: test
    files:
      - dv/rename_asserts.sv
      - dv/rename_tb.sv
